/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem simulation with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -j 0 -f sim.f --top-module mem_subsys_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmem_subsys_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

/* sim.f */
verilog/segre_pkg.sv
verilog/mem_req_if.sv
verilog/apb_mem_port.sv
verilog/mem_req_fifo.sv
verilog/memory.sv
verilog/mem_subsys_top.sv
testbench/mem_subsys_tb.sv

/* testbench/mem_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

    localparam int NUM_ENTRIES = 22;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (segre_pkg::REQ_FIFO_DEPTH + 2) *
                                    (segre_pkg::REQUEST_DURATION + 2) + 100;
    localparam logic [7:0] PRELOAD_PATTERN = 8'h5a;
    localparam int MODEL_BYTES = 1024;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp_rdata;
        logic        exp_err;
        logic        chained;
    } entry_t;

    logic                                clk_i;
    logic                                rst_n_i;
    logic                                psel_i;
    logic                                penable_i;
    logic                                pwrite_i;
    logic [segre_pkg::WORD_SIZE-1:0]     paddr_i;
    logic [segre_pkg::WORD_SIZE-1:0]     pwdata_i;
    logic [segre_pkg::WORD_BYTES-1:0]    pstrb_i;
    logic                                pready_o;
    logic [segre_pkg::WORD_SIZE-1:0]     prdata_o;
    logic                                pslverr_o;

    entry_t     entries [NUM_ENTRIES];
    int         n_entries = 0;
    logic [7:0] model_mem [MODEL_BYTES];
    int         cycle_count = 0;

    mem_subsys_top dut0 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pstrb_i   (pstrb_i),
        .pready_o  (pready_o),
        .prdata_o  (prdata_o),
        .pslverr_o (pslverr_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Test failed");
            $fatal(1, "Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Check on %s failed", name);
        end
    endtask

    // Table entry with its expected response taken from the byte model
    task automatic add_entry(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic chained);
        entry_t e;
        int     base;
        e.write     = wr;
        e.addr      = addr;
        e.data      = data;
        e.strb      = strb;
        e.chained   = chained;
        e.exp_err   = addr >= 32'(MODEL_BYTES);
        e.exp_rdata = '0;
        base        = {22'b0, addr[9:2], 2'b00};
        if (!e.exp_err && wr) begin
            for (int j = 0; j < 4; j++) begin
                if (strb[j]) begin
                    model_mem[base + j] = data[8*j +: 8];
                end
            end
        end else if (!e.exp_err) begin
            e.exp_rdata = {model_mem[base + 3], model_mem[base + 2],
                           model_mem[base + 1], model_mem[base]};
        end
        entries[n_entries] = e;
        n_entries++;
    endtask

    // Starts right after a rising edge, ends right after the completing edge
    task automatic apb_transfer(input int idx);
        entry_t e;
        e         = entries[idx];
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = e.write;
        paddr_i   = e.addr;
        pwdata_i  = e.write ? e.data : '0;
        pstrb_i   = e.write ? e.strb : '0;
        @(posedge clk_i);
        #1;
        penable_i = 1'b1;
        @(negedge clk_i);
        while (!pready_o) begin
            @(negedge clk_i);
        end
        check_value("pslverr_o", 32'(pslverr_o), 32'(e.exp_err));
        if (!e.write && !e.exp_err) begin
            check_value("prdata_o", prdata_o, e.exp_rdata);
        end
        @(posedge clk_i);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    initial begin
        int idle;
        void'($urandom(32'hc34e));
        clk_i     = 1'b0;
        rst_n_i   = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        pstrb_i   = '0;

        for (int a = 0; a < MODEL_BYTES; a++) begin
            model_mem[a] = 8'(a) ^ PRELOAD_PATTERN;
        end

        // Untouched words show the preload
        add_entry(1'b0, 32'h000, 32'h0, 4'h0, 1'b0);
        add_entry(1'b0, 32'h104, 32'h0, 4'h0, 1'b0);
        add_entry(1'b0, 32'h3fc, 32'h0, 4'h0, 1'b0);
        add_entry(1'b1, 32'h040, 32'hdeadbeef, 4'hf, 1'b0);
        add_entry(1'b0, 32'h040, 32'h0, 4'h0, 1'b0);
        // Partial strobes in two different words of one line
        add_entry(1'b1, 32'h084, 32'h11223344, 4'b0101, 1'b0);
        add_entry(1'b0, 32'h084, 32'h0, 4'h0, 1'b0);
        add_entry(1'b1, 32'h08c, 32'ha5a5a5a5, 4'b1010, 1'b0);
        add_entry(1'b0, 32'h08c, 32'h0, 4'h0, 1'b0);
        // Five back-to-back posted writes fill the FIFO and the read must see the last one
        add_entry(1'b1, 32'h0c8, 32'h00000001, 4'hf, 1'b0);
        add_entry(1'b1, 32'h0c8, 32'h00000022, 4'hf, 1'b1);
        add_entry(1'b1, 32'h0c8, 32'h00000333, 4'hf, 1'b1);
        add_entry(1'b1, 32'h0c8, 32'h00004444, 4'hf, 1'b1);
        add_entry(1'b1, 32'h0c8, 32'h55555555, 4'hf, 1'b1);
        add_entry(1'b0, 32'h0c8, 32'h0, 4'h0, 1'b1);
        add_entry(1'b0, 32'h0cc, 32'h0, 4'h0, 1'b0);
        // Out-of-range accesses at 0x400 and 0x404 would alias to 0x000 and 0x004
        add_entry(1'b1, 32'h400, 32'hcafef00d, 4'hf, 1'b0);
        add_entry(1'b0, 32'h400, 32'h0, 4'h0, 1'b0);
        add_entry(1'b1, 32'hfffffff0, 32'h12345678, 4'hf, 1'b0);
        add_entry(1'b1, 32'h404, 32'h0badcafe, 4'b0011, 1'b0);
        add_entry(1'b0, 32'h000, 32'h0, 4'h0, 1'b0);
        add_entry(1'b0, 32'h004, 32'h0, 4'h0, 1'b0);

        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        @(negedge clk_i);
        check_value("pready_o", 32'(pready_o), 32'h0);
        check_value("pslverr_o", 32'(pslverr_o), 32'h0);
        @(posedge clk_i);
        #1;

        for (int i = 0; i < n_entries; i++) begin
            idle = int'($urandom % 3);
            // Burst entries follow the previous transfer without a gap
            if (entries[i].chained) begin
                idle = 0;
            end
            repeat (idle) begin
                @(posedge clk_i);
                #1;
            end
            apb_transfer(i);
        end

        repeat (2) @(posedge clk_i);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/apb_mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_mem_port (
    input  wire                                              clk_i,
    input  wire                                              rst_n_i,
    input  wire                                              psel_i,
    input  wire                                              penable_i,
    input  wire                                              pwrite_i,
    input  wire  [segre_pkg::WORD_SIZE-1:0]                  pwdata_i,
    input  wire  [segre_pkg::WORD_SIZE-1:0]                  paddr_i,
    input  wire  [segre_pkg::WORD_BYTES-1:0]                 pstrb_i,
    output logic                                             pready_o,
    output logic [segre_pkg::WORD_SIZE-1:0]                  prdata_o,
    output logic                                             pslverr_o,
    mem_req_if.sender                                        req_o,
    input  wire                                              rsp_valid_i,
    input  wire  [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0][7:0] rsp_line_i
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACCEPT,
        WAIT_RSP,
        DONE
    } port_state_e;

    port_state_e state_q;
    port_state_e state_d;

    logic                                         access;
    logic                                         addr_err;
    logic                                         issue;
    logic                                         accepted;
    logic [segre_pkg::WORD_SEL_BITS-1:0]          word_sel;
    logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0]  strb_ext;
    logic [segre_pkg::WORDS_PER_LINE-1:0][segre_pkg::WORD_SIZE-1:0] rsp_words;

    assign access   = psel_i && penable_i;
    assign addr_err = paddr_i >= segre_pkg::MEM_BYTES;
    assign word_sel = paddr_i[segre_pkg::LINE_OFFSET_BITS-1:segre_pkg::BYTE_SEL_BITS];
    assign strb_ext = {{(segre_pkg::CACHE_LINE_SIZE_BYTES - segre_pkg::WORD_BYTES){1'b0}},
                       pstrb_i};

    // Request stays up until the FIFO takes it
    assign issue    = access && !addr_err && (state_q == IDLE || state_q == WAIT_ACCEPT);
    assign accepted = issue && req_o.ready;

    assign req_o.valid = issue;
    assign req_o.op    = pwrite_i ? segre_pkg::MEM_WR : segre_pkg::MEM_RD;
    assign req_o.addr  = {paddr_i[segre_pkg::WORD_SIZE-1:segre_pkg::LINE_OFFSET_BITS],
                          {segre_pkg::LINE_OFFSET_BITS{1'b0}}};
    // Word copied into every slot, the byte enables pick the right one
    assign req_o.data    = {segre_pkg::WORDS_PER_LINE{pwdata_i}};
    assign req_o.byte_en = pwrite_i ? strb_ext << (word_sel * segre_pkg::WORD_BYTES) : '0;

    // Posted writes finish on acceptance, reads finish one cycle after the response
    assign pslverr_o = access && addr_err && state_q == IDLE;
    assign pready_o  = (state_q == DONE) || (accepted && pwrite_i) || pslverr_o;

    assign rsp_words = rsp_line_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, WAIT_ACCEPT: begin
                if (accepted) begin
                    state_d = pwrite_i ? IDLE : WAIT_RSP;
                end else if (issue) begin
                    state_d = WAIT_ACCEPT;
                end
            end
            WAIT_RSP: begin
                if (rsp_valid_i) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            prdata_o <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == WAIT_RSP && rsp_valid_i) begin
                prdata_o <= rsp_words[word_sel];
            end
        end
    end

    apb_enable_needs_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        penable_i |-> psel_i);

    // The memory answers only the single read this port has outstanding
    rsp_only_when_waiting: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> state_q == WAIT_RSP);

endmodule

`default_nettype wire

/* verilog/mem_req_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_req_fifo (
    input wire          clk_i,
    input wire          rst_n_i,
    mem_req_if.receiver push_i,
    mem_req_if.sender   pop_o
);

    segre_pkg::mem_op_e                               op_q    [segre_pkg::REQ_FIFO_DEPTH];
    logic [segre_pkg::WORD_SIZE-1:0]                  addr_q  [segre_pkg::REQ_FIFO_DEPTH];
    logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0][7:0] data_q  [segre_pkg::REQ_FIFO_DEPTH];
    logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0]      be_q    [segre_pkg::REQ_FIFO_DEPTH];

    segre_pkg::fifo_ptr_t wr_ptr;
    segre_pkg::fifo_ptr_t rd_ptr;
    segre_pkg::fifo_cnt_t count;
    logic                 do_push;
    logic                 do_pop;

    function automatic segre_pkg::fifo_ptr_t next_ptr(input segre_pkg::fifo_ptr_t ptr);
        if (ptr == segre_pkg::fifo_ptr_t'(segre_pkg::REQ_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_i.ready = count != segre_pkg::fifo_cnt_t'(segre_pkg::REQ_FIFO_DEPTH);
    assign do_push      = push_i.valid && push_i.ready;
    assign do_pop       = pop_o.valid && pop_o.ready;

    // Oldest entry is always on the output
    assign pop_o.valid   = count != '0;
    assign pop_o.op      = op_q[rd_ptr];
    assign pop_o.addr    = addr_q[rd_ptr];
    assign pop_o.data    = data_q[rd_ptr];
    assign pop_o.byte_en = be_q[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            op_q[wr_ptr]   <= push_i.op;
            addr_q[wr_ptr] <= push_i.addr;
            data_q[wr_ptr] <= push_i.data;
            be_q[wr_ptr]   <= push_i.byte_en;
        end
    end

    count_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count <= segre_pkg::fifo_cnt_t'(segre_pkg::REQ_FIFO_DEPTH));

    // A stalled push must wait unchanged for the next edge
    push_held_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i.valid && !push_i.ready |=>
            push_i.valid && $stable(push_i.op) && $stable(push_i.addr));

endmodule

`default_nettype wire

/* verilog/mem_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One cache-line request, valid/ready handshake
interface mem_req_if;

    logic                                             valid;
    logic                                             ready;
    segre_pkg::mem_op_e                               op;
    logic [segre_pkg::WORD_SIZE-1:0]                  addr;
    logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0][7:0] data;
    logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0]      byte_en;

    modport sender (
        output valid,
        output op,
        output addr,
        output data,
        output byte_en,
        input  ready
    );

    modport receiver (
        input  valid,
        input  op,
        input  addr,
        input  data,
        input  byte_en,
        output ready
    );

endinterface

`default_nettype wire

/* verilog/mem_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  wire                              clk_i,
    input  wire                              rst_n_i,
    input  wire                              psel_i,
    input  wire                              penable_i,
    input  wire                              pwrite_i,
    input  wire  [segre_pkg::WORD_SIZE-1:0]  paddr_i,
    input  wire  [segre_pkg::WORD_SIZE-1:0]  pwdata_i,
    input  wire  [segre_pkg::WORD_BYTES-1:0] pstrb_i,
    output logic                             pready_o,
    output logic [segre_pkg::WORD_SIZE-1:0]  prdata_o,
    output logic                             pslverr_o
);

    mem_req_if req_in ();
    mem_req_if req_out ();

    // Line response back to the APB side
    logic                                             rsp_valid;
    logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0][7:0] rsp_line;

    apb_mem_port port0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .paddr_i     (paddr_i),
        .pstrb_i     (pstrb_i),
        .pready_o    (pready_o),
        .prdata_o    (prdata_o),
        .pslverr_o   (pslverr_o),
        .req_o       (req_in),
        .rsp_valid_i (rsp_valid),
        .rsp_line_i  (rsp_line)
    );

    mem_req_fifo fifo0 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (req_in),
        .pop_o   (req_out)
    );

    memory mem0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_out),
        .rsp_valid_o (rsp_valid),
        .rsp_line_o  (rsp_line)
    );

endmodule

`default_nettype wire

/* verilog/memory.sv */
`timescale 1ns/1ps
`default_nettype none

module memory (
    input  wire                                              clk_i,
    input  wire                                              rst_n_i,
    mem_req_if.receiver                                      req_i,
    output logic                                             rsp_valid_o,
    output logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0][7:0] rsp_line_o
);

    logic [7:0] mem [segre_pkg::MEM_BYTES];

    segre_pkg::mem_cnt_t                              cyc_cnt;
    segre_pkg::mem_op_e                               op_q;
    segre_pkg::mem_addr_t                             line_base;
    logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0][7:0] data_q;
    logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0]      be_q;
    logic                                             accept;
    logic                                             last_cycle;

    // Known power-up contents
    initial begin
        for (int a = 0; a < segre_pkg::MEM_BYTES; a++) begin
            mem[a] = 8'(a) ^ segre_pkg::PRELOAD_XOR;
        end
    end

    // Only idle memory takes a new request
    assign req_i.ready = cyc_cnt == '0;
    assign accept      = req_i.valid && req_i.ready;
    assign last_cycle  = cyc_cnt == segre_pkg::mem_cnt_t'(1);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cyc_cnt <= '0;
        end else if (accept) begin
            cyc_cnt <= segre_pkg::mem_cnt_t'(segre_pkg::REQUEST_DURATION);
        end else if (cyc_cnt != '0) begin
            cyc_cnt <= cyc_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q      <= req_i.op;
            line_base <= req_i.addr[segre_pkg::MEM_ADDR_BITS-1:0];
            data_q    <= req_i.data;
            be_q      <= req_i.byte_en;
        end
    end

    // Write lands on the final counted cycle
    always @(posedge clk_i) begin
        if (last_cycle && op_q == segre_pkg::MEM_WR) begin
            for (int i = 0; i < segre_pkg::CACHE_LINE_SIZE_BYTES; i++) begin
                if (be_q[i]) begin
                    mem[line_base + segre_pkg::mem_addr_t'(i)] <= data_q[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < segre_pkg::CACHE_LINE_SIZE_BYTES; i++) begin
            rsp_line_o[i] = mem[line_base + segre_pkg::mem_addr_t'(i)];
        end
    end

    assign rsp_valid_o = last_cycle && op_q == segre_pkg::MEM_RD;

    // No second request gets in while the current one is still being served
    no_accept_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |=> !accept [*segre_pkg::REQUEST_DURATION]);

endmodule

`default_nettype wire

/* verilog/segre_pkg.sv */
`default_nettype none

package segre_pkg;

    // Bus and line geometry
    localparam int WORD_SIZE             = 32;
    localparam int WORD_BYTES            = WORD_SIZE / 8;
    localparam int CACHE_LINE_SIZE_BYTES = 16;
    localparam int WORDS_PER_LINE        = CACHE_LINE_SIZE_BYTES / WORD_BYTES;
    localparam int LINE_OFFSET_BITS      = $clog2(CACHE_LINE_SIZE_BYTES);
    localparam int BYTE_SEL_BITS         = $clog2(WORD_BYTES);
    localparam int WORD_SEL_BITS         = $clog2(WORDS_PER_LINE);

    // Backing store, anything at or above MEM_BYTES is rejected
    localparam int MEM_BYTES     = 1024;
    localparam int MEM_ADDR_BITS = $clog2(MEM_BYTES);

    // Cycles the memory needs per line request
    localparam int REQUEST_DURATION = 9;
    localparam int MEM_CNT_BITS     = $clog2(REQUEST_DURATION + 1);

    localparam int REQ_FIFO_DEPTH = 4;
    localparam int FIFO_PTR_BITS  = $clog2(REQ_FIFO_DEPTH);
    localparam int FIFO_CNT_BITS  = $clog2(REQ_FIFO_DEPTH + 1);

    // Byte at address a powers up as a[7:0] ^ PRELOAD_XOR
    localparam logic [7:0] PRELOAD_XOR = 8'h5a;

    typedef logic [FIFO_PTR_BITS-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_BITS-1:0] fifo_cnt_t;
    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [MEM_CNT_BITS-1:0]  mem_cnt_t;

    typedef enum logic {
        MEM_RD,
        MEM_WR
    } mem_op_e;

endpackage

`default_nettype wire
